// File: verilog/acc_cpu_pkg.sv
package acc_cpu_pkg;

  // datapath width and register file size
  localparam int WORD_W   = 8;
  localparam int RF_DEPTH = 16;

  // op form opcodes, codes 14 and 15 decode as nop
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_xor  = 4'd4,
    op_shl  = 4'd5,
    op_shr  = 4'd6,
    op_ld   = 4'd7,
    op_st   = 4'd8,
    op_li   = 4'd9,
    op_beq  = 4'd10,
    op_bne  = 4'd11,
    op_jmp  = 4'd12,
    op_halt = 4'd13
  } opcode_e;

  // put form, pushes imm onto the accumulator stack
  typedef struct packed {
    logic              is_put;
    logic [WORD_W-1:0] imm;
  } put_form_t;

  // op form, low nibble is ignored
  typedef struct packed {
    logic       is_put;
    opcode_e    op;
    logic [3:0] rsvd;
  } op_form_t;

  // 9-bit instruction word, bit 8 picks the view
  typedef union packed {
    put_form_t put;
    op_form_t  cmd;
  } instr_u;

  typedef struct packed {
    logic    reg_we;
    logic    mem_we;
    logic    mem_to_reg;
    logic    imm_to_reg;
    logic    put_en;
    logic    op_en;
    logic    halt;
    opcode_e alu_op;
  } ctrl_t;

  // host program load bus
  typedef struct packed {
    logic       we;
    logic [7:0] addr;
    instr_u     word;
  } prog_wr_t;

endpackage

// File: verilog/prog_counter.sv
`timescale 1ns/1ps

module prog_counter #(
  parameter int PROG_DEPTH = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req,
  input  logic                          jump,
  input  logic                          branch_taken,
  input  logic                          halt,
  input  logic [7:0]                    target,
  output logic [$clog2(PROG_DEPTH)-1:0] pc,
  output logic                          running,
  output logic                          done
);

  localparam int PC_W = $clog2(PROG_DEPTH);

  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      done    <= 1'b0;
      pc      <= '0;
    end else if (!running) begin
      // idle, only a start pulse matters here
      if (req) begin
        running <= 1'b1;
        done    <= 1'b0;
        pc      <= '0;
      end
    end else if (halt) begin
      running <= 1'b0;
      done    <= 1'b1;
    end else if (jump || branch_taken) begin
      // absolute target from r0
      pc <= target[PC_W-1:0];
    end else begin
      pc <= pc + 1'b1;
    end
  end

endmodule

// File: verilog/instr_rom.sv
`timescale 1ns/1ps

module instr_rom import acc_cpu_pkg::*; #(
  parameter int PROG_DEPTH = 256
) (
  input  logic                          clk,
  input  prog_wr_t                      prog_wr,
  input  logic                          running,
  input  logic [$clog2(PROG_DEPTH)-1:0] pc,
  output instr_u                        instr
);

  localparam int PC_W = $clog2(PROG_DEPTH);

  instr_u prog [PROG_DEPTH];

  logic load_ok;

  // host loads only while idle and inside the store
  assign load_ok = prog_wr.we && !running && (int'(prog_wr.addr) < PROG_DEPTH);

  always_ff @(posedge clk) begin
    if (load_ok) begin
      prog[prog_wr.addr[PC_W-1:0]] <= prog_wr.word;
    end
  end

  // fetch is combinational
  assign instr = prog[pc];

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ps

module decoder import acc_cpu_pkg::*; (
  input  instr_u            instr,
  input  logic              running,
  output ctrl_t             ctrl,
  output logic [WORD_W-1:0] put_value,
  output logic              jump
);

  // immediate passes through, put_en decides if it lands
  assign put_value = instr.put.imm;

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = op_nop;
    jump        = 1'b0;
    if (running) begin
      if (instr.put.is_put) begin
        ctrl.put_en = 1'b1;
      end else begin
        ctrl.op_en  = 1'b1;
        ctrl.alu_op = instr.cmd.op;
        case (instr.cmd.op)
          op_add, op_sub, op_and, op_xor, op_shl, op_shr: begin
            ctrl.reg_we = 1'b1;
          end
          op_ld: begin
            ctrl.reg_we     = 1'b1;
            ctrl.mem_to_reg = 1'b1;
          end
          op_st: begin
            ctrl.mem_we = 1'b1;
          end
          op_li: begin
            ctrl.reg_we     = 1'b1;
            ctrl.imm_to_reg = 1'b1;
          end
          op_beq, op_bne: begin
            // the alu makes the compare
          end
          op_jmp: begin
            jump = 1'b1;
          end
          op_halt: begin
            ctrl.halt = 1'b1;
          end
          default: begin
            // nop and the two spare codes
            ctrl.alu_op = op_nop;
          end
        endcase
      end
    end
  end

endmodule

// File: verilog/accumulator.sv
`timescale 1ns/1ps

module accumulator import acc_cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              put_en,
  input  logic [WORD_W-1:0] put_value,
  output logic [WORD_W-1:0] r0,
  output logic [WORD_W-1:0] r1,
  output logic [WORD_W-1:0] r2
);

  // three-deep stack, r0 is the newest
  always_ff @(posedge clk) begin
    if (rst) begin
      r0 <= '0;
      r1 <= '0;
      r2 <= '0;
    end else if (put_en) begin
      r2 <= r1;
      r1 <= r0;
      r0 <= put_value;
    end
  end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import acc_cpu_pkg::*; (
  input  opcode_e           alu_op,
  input  logic [WORD_W-1:0] in_a,
  input  logic [WORD_W-1:0] in_b,
  output logic [WORD_W-1:0] result,
  output logic              branch_taken
);

  logic [2:0] shamt;

  // shift distance wraps at the word width
  assign shamt = in_b[2:0];

  always_comb begin
    result       = '0;
    branch_taken = 1'b0;
    case (alu_op)
      op_add: begin
        result = in_a + in_b;
      end
      op_sub: begin
        result = in_a - in_b;
      end
      op_and: begin
        result = in_a & in_b;
      end
      op_xor: begin
        result = in_a ^ in_b;
      end
      // zero filled, no carry out
      op_shl: begin
        result = in_a << shamt;
      end
      op_shr: begin
        result = in_a >> shamt;
      end
      op_beq: begin
        branch_taken = (in_a == in_b);
      end
      op_bne: begin
        branch_taken = (in_a != in_b);
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file import acc_cpu_pkg::*; (
  input  logic                        clk,
  input  ctrl_t                       ctrl,
  input  logic [$clog2(RF_DEPTH)-1:0] rd_addr_a,
  input  logic [$clog2(RF_DEPTH)-1:0] rd_addr_b,
  input  logic [$clog2(RF_DEPTH)-1:0] wr_addr,
  input  logic [WORD_W-1:0]           alu_result,
  input  logic [WORD_W-1:0]           mem_data,
  input  logic [WORD_W-1:0]           imm,
  output logic [WORD_W-1:0]           dat_a,
  output logic [WORD_W-1:0]           dat_b
);

  logic [WORD_W-1:0] core [RF_DEPTH];
  logic [WORD_W-1:0] wr_data;
  logic              wr_en;

  // write-back source, memory first, then li, then alu
  always_comb begin
    if (ctrl.mem_to_reg) begin
      wr_data = mem_data;
    end else if (ctrl.imm_to_reg) begin
      wr_data = imm;
    end else begin
      wr_data = alu_result;
    end
  end

  // only op form instructions write back
  assign wr_en = ctrl.reg_we && ctrl.op_en;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      core[wr_addr] <= wr_data;
    end
  end

  assign dat_a = core[rd_addr_a];
  assign dat_b = core[rd_addr_b];

endmodule

// File: verilog/dat_mem.sv
`timescale 1ns/1ps

module dat_mem import acc_cpu_pkg::*; (
  input  logic              clk,
  input  logic              we,
  input  logic [7:0]        addr,
  input  logic [WORD_W-1:0] wdata,
  input  logic [7:0]        host_addr,
  output logic [WORD_W-1:0] rdata,
  output logic [WORD_W-1:0] host_rdata
);

  logic [WORD_W-1:0] mem [256];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // processor port for ld
  assign rdata = mem[addr];

  // host port, meaningful once the run is done
  assign host_rdata = mem[host_addr];

endmodule

// File: verilog/acc_cpu_top.sv
`timescale 1ns/1ps

module acc_cpu_top import acc_cpu_pkg::*; #(
  parameter int PROG_DEPTH = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  output logic              done,
  input  prog_wr_t          prog_wr,
  input  logic [7:0]        host_addr,
  output logic [WORD_W-1:0] host_rdata
);

  localparam int PC_W = $clog2(PROG_DEPTH);

  logic [PC_W-1:0]   pc;
  logic              running;
  instr_u            instr;
  ctrl_t             ctrl;
  logic [WORD_W-1:0] put_value;
  logic              jump;
  logic [WORD_W-1:0] r0, r1, r2;
  logic [WORD_W-1:0] dat_a, dat_b;
  logic [WORD_W-1:0] alu_result;
  logic              branch_taken;
  logic [WORD_W-1:0] mem_data;

  prog_counter #(.PROG_DEPTH(PROG_DEPTH)) u_pc (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .jump         (jump),
    .branch_taken (branch_taken),
    .halt         (ctrl.halt),
    .target       (r0),
    .pc           (pc),
    .running      (running),
    .done         (done)
  );

  instr_rom #(.PROG_DEPTH(PROG_DEPTH)) u_rom (
    .clk     (clk),
    .prog_wr (prog_wr),
    .running (running),
    .pc      (pc),
    .instr   (instr)
  );

  decoder u_dec (
    .instr     (instr),
    .running   (running),
    .ctrl      (ctrl),
    .put_value (put_value),
    .jump      (jump)
  );

  accumulator u_acc (
    .clk       (clk),
    .rst       (rst),
    .put_en    (ctrl.put_en),
    .put_value (put_value),
    .r0        (r0),
    .r1        (r1),
    .r2        (r2)
  );

  // operands at r1 and r2, result to r0, low nibble only
  reg_file u_rf (
    .clk        (clk),
    .ctrl       (ctrl),
    .rd_addr_a  (r1[3:0]),
    .rd_addr_b  (r2[3:0]),
    .wr_addr    (r0[3:0]),
    .alu_result (alu_result),
    .mem_data   (mem_data),
    .imm        (r1),
    .dat_a      (dat_a),
    .dat_b      (dat_b)
  );

  alu u_alu (
    .alu_op       (ctrl.alu_op),
    .in_a         (dat_a),
    .in_b         (dat_b),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  dat_mem u_dm (
    .clk        (clk),
    .we         (ctrl.mem_we),
    .addr       (dat_a),
    .wdata      (dat_b),
    .host_addr  (host_addr),
    .rdata      (mem_data),
    .host_rdata (host_rdata)
  );

endmodule

// File: bench/acc_cpu_assertions.sv
`timescale 1ns/1ps

module acc_cpu_assertions #(
  parameter int PROG_DEPTH = 256
) (
  input logic                          clk,
  input logic                          rst,
  input logic                          running,
  input logic                          done,
  input logic                          mem_we,
  input logic                          jump,
  input logic                          branch_taken,
  input logic                          halt,
  input logic [$clog2(PROG_DEPTH)-1:0] pc
);

  int fail_count = 0;

  // idle with result and running are exclusive
  done_not_running: assert property (@(posedge clk) disable iff (rst)
    !(done && running))
    else begin
      $error("done and running are both high");
      fail_count++;
    end

  idle_no_mem_write: assert property (@(posedge clk) disable iff (rst)
    !running |-> !mem_we)
    else begin
      $error("data memory written while idle");
      fail_count++;
    end

  // straight-line fetch
  pc_steps_by_one: assert property (@(posedge clk) disable iff (rst)
    running && !halt && !jump && !branch_taken |=> pc == $past(pc) + 1'b1)
    else begin
      $error("pc did not advance by one");
      fail_count++;
    end

endmodule

bind acc_cpu_top acc_cpu_assertions #(.PROG_DEPTH(PROG_DEPTH)) u_assert (
  .clk          (clk),
  .rst          (rst),
  .running      (running),
  .done         (done),
  .mem_we       (ctrl.mem_we),
  .jump         (jump),
  .branch_taken (branch_taken),
  .halt         (ctrl.halt),
  .pc           (pc)
);

// File: bench/acc_cpu_tb.sv
`timescale 1ns/1ps

module acc_cpu_tb import acc_cpu_pkg::*; ();

  localparam int NUM_PROGS   = 40;
  localparam int MAX_LEN     = 64;
  localparam int CLK_NS      = 8;
  localparam int WATCHDOG_NS = NUM_PROGS * (MAX_LEN + MAX_LEN + 256 + 20) * CLK_NS;

  logic                    clk;
  logic                    rst;
  logic                    req;
  logic                    done;
  prog_wr_t                prog_wr;
  logic [7:0]              host_addr;
  logic [7:0]              host_rdata;
  integer                  seed;
  logic [MAX_LEN-1:0][8:0] gen_words;
  int                      gen_len;
  logic [15:0]             live;
  logic [255:0][7:0]       exp_img;
  logic [255:0]            exp_mask;
  int                      exp_steps;
  event                    run_done;
  event                    check_finished;

  acc_cpu_top dut (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .done       (done),
    .prog_wr    (prog_wr),
    .host_addr  (host_addr),
    .host_rdata (host_rdata)
  );

  always #(CLK_NS / 2) clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic int rand_below(input int k);
    return int'($unsigned($random(seed)) % k);
  endfunction

  function automatic void emit_put(input int v);
    gen_words[gen_len] = {1'b1, 8'(v)};
    gen_len++;
  endfunction

  function automatic void emit_op(input opcode_e op);
    gen_words[gen_len] = {1'b0, op, 4'h0};
    gen_len++;
  endfunction

  // random register index that already holds a value
  function automatic int pick_live();
    int r;
    r = rand_below(16);
    while (!live[r]) begin
      r = rand_below(16);
    end
    return r;
  endfunction

  // put v, put d, li gives rf[d] = v
  function automatic void add_init();
    int d;
    d = rand_below(16);
    emit_put(rand_below(256));
    emit_put(d);
    emit_op(op_li);
    live[d] = 1'b1;
  endfunction

  // mem[rf[c]] = rf[d] in 4 words
  function automatic void add_store(input int d);
    emit_put(d);
    emit_put(pick_live());
    emit_put(rand_below(256));
    emit_op(op_st);
  endfunction

  // alu op into rf[d] and a store of the result in 8 words
  function automatic void add_alu();
    int d;
    d = pick_live();
    emit_put(pick_live());
    emit_put(pick_live());
    emit_put(d);
    emit_op(opcode_e'(4'(1 + rand_below(6))));
    add_store(d);
  endfunction

  // store then load back and store the loaded byte in 11 words
  function automatic void add_ldst();
    int a;
    int d;
    a = pick_live();
    d = pick_live();
    emit_put(pick_live());
    emit_put(a);
    emit_put(0);
    emit_op(op_st);
    emit_put(a);
    emit_put(d);
    emit_op(op_ld);
    add_store(d);
  endfunction

  // forward branch or jump over the block that follows
  function automatic void add_skip(input logic use_jmp);
    int   a;
    int   b;
    logic shadow_ldst;
    a = pick_live();
    b = rand_below(2) ? a : pick_live();
    shadow_ldst = (rand_below(2) == 1);
    if (use_jmp) begin
      emit_put(gen_len + 2 + (shadow_ldst ? 11 : 8));
      emit_op(op_jmp);
    end else begin
      emit_put(b);
      emit_put(a);
      emit_put(gen_len + 2 + (shadow_ldst ? 11 : 8));
      emit_op(rand_below(2) ? op_beq : op_bne);
    end
    if (shadow_ldst) begin
      add_ldst();
    end else begin
      add_alu();
    end
  endfunction

  function automatic void build_program();
    gen_words = '0;
    gen_len   = 0;
    live      = '0;
    repeat (3) add_init();
    add_alu();
    // largest block is 15 words so halt still fits
    while (gen_len < 44) begin
      case (rand_below(5))
        0: add_init();
        1: add_alu();
        2: add_ldst();
        3: add_skip(1'b0);
        default: add_skip(1'b1);
      endcase
    end
    emit_op(op_halt);
  endfunction

  // ISA interpreter returning the number of executed instructions
  function automatic int acc_cpu_model(
    input  logic [MAX_LEN-1:0][8:0] words,
    input  int                      n,
    inout  logic [255:0][7:0]       img,
    output logic [255:0]            mask
  );
    logic [7:0] rf [16];
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] x;
    logic [7:0] y;
    logic [8:0] w;
    int         pc;
    int         steps;
    mask  = '0;
    a0    = '0;
    a1    = '0;
    a2    = '0;
    pc    = 0;
    steps = 0;
    foreach (rf[i]) rf[i] = '0;
    while (pc < n && steps < 256) begin
      w = words[pc];
      steps++;
      pc++;
      if (w[8]) begin
        a2 = a1;
        a1 = a0;
        a0 = w[7:0];
      end else begin
        x = rf[a1[3:0]];
        y = rf[a2[3:0]];
        case (opcode_e'(w[7:4]))
          op_add:  rf[a0[3:0]] = x + y;
          op_sub:  rf[a0[3:0]] = x - y;
          op_and:  rf[a0[3:0]] = x & y;
          op_xor:  rf[a0[3:0]] = x ^ y;
          op_shl:  rf[a0[3:0]] = x << y[2:0];
          op_shr:  rf[a0[3:0]] = x >> y[2:0];
          op_ld:   rf[a0[3:0]] = img[x];
          op_li:   rf[a0[3:0]] = a1;
          op_beq:  pc = (x == y) ? int'(a0) : pc;
          op_bne:  pc = (x != y) ? int'(a0) : pc;
          op_jmp:  pc = a0;
          op_halt: return steps;
          op_st: begin
            img[x]  = y;
            mask[x] = 1'b1;
          end
          default: ;
        endcase
      end
    end
    return steps;
  endfunction

  task automatic load_program(input logic done_level);
    for (int i = 0; i < gen_len; i++) begin
      @(negedge clk);
      // done holds its level while the host loads
      assert (done === done_level) else abort_run($sformatf(
        "Fail at %0t ns: done is %b during load, expected %b", $time, done, done_level));
      prog_wr.we   = 1'b1;
      prog_wr.addr = 8'(i);
      prog_wr.word = gen_words[i];
    end
    @(negedge clk);
    prog_wr = '0;
  endtask

  task automatic run_program();
    int cycles;
    @(negedge clk);
    req = 1'b1;
    @(negedge clk);
    req = 1'b0;
    assert (done === 1'b0) else abort_run($sformatf(
      "Fail at %0t ns: done still high after req", $time));
    cycles = 0;
    while (done !== 1'b1) begin
      @(negedge clk);
      cycles++;
    end
    assert (cycles == exp_steps) else abort_run($sformatf(
      "Fail at %0t ns: run took %0d cycles, expected %0d", $time, cycles, exp_steps));
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    req       = 1'b0;
    prog_wr   = '0;
    seed      = 74;
    exp_img   = '0;
    exp_mask  = '0;
    exp_steps = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program();
      exp_steps = acc_cpu_model(gen_words, gen_len, exp_img, exp_mask);
      load_program(p > 0);
      run_program();
      -> run_done;
      @(check_finished);
    end
    if (dut.u_assert.fail_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run("a protocol assertion in the bound checker failed");
    end
  end

  always @(posedge clk) begin
    assert (dut.u_assert.fail_count == 0) else abort_run(
      "a protocol assertion in the bound checker failed");
  end

  // read back every byte the last program wrote
  initial begin
    host_addr = '0;
    forever begin
      @(run_done);
      for (int a = 0; a < 256; a++) begin
        if (exp_mask[a]) begin
          @(negedge clk);
          host_addr = 8'(a);
          @(posedge clk);
          assert (host_rdata === exp_img[a]) else abort_run($sformatf(
            "Fail at %0t ns: mem[%02h] is %02h, expected %02h",
            $time, a, host_rdata, exp_img[a]));
        end
      end
      -> check_finished;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: done never arrived within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: sim.f
verilog/acc_cpu_pkg.sv
verilog/prog_counter.sv
verilog/instr_rom.sv
verilog/decoder.sv
verilog/accumulator.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/dat_mem.sv
verilog/acc_cpu_top.sv
bench/acc_cpu_assertions.sv
bench/acc_cpu_tb.sv

// File: Bender.yml
package:
  name: acc_cpu

sources:
  - files:
      - verilog/acc_cpu_pkg.sv
      - verilog/prog_counter.sv
      - verilog/instr_rom.sv
      - verilog/decoder.sv
      - verilog/accumulator.sv
      - verilog/alu.sv
      - verilog/reg_file.sv
      - verilog/dat_mem.sv
      - verilog/acc_cpu_top.sv
  - target: test
    files:
      - bench/acc_cpu_assertions.sv
      - bench/acc_cpu_tb.sv
